//--- compile.f
common/vseq_pkg.sv
common/vseq_if.sv
hw/scoreboard/vseq_scoreboard.sv
hw/vseq_unit_counter.sv
hw/vseq_running_tracker.sv
hw/vseq_issue_ctrl.sv
hw/vseq_top.sv
verification/vseq_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the sequencer testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module vseq_tb -f compile.f -o vseq_sim

# The simulation output decides the result
out=$(./obj_dir/vseq_sim || true)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -q "SIMULATION PASSED"

//--- verification/vseq_tb.sv
/*
  Random-stimulus testbench of the vector instruction sequencer.
  A cycle model of running table, access lists, queue counters, hazard table
  and issue stage predicts every output, which is compared each cycle.
*/
`timescale 1ns/1ps

module vseq_tb;

  localparam int unsigned QueueDepth = vseq_pkg::DefaultQueueDepth;

  logic                                       clk_i = 1'b0;
  logic                                       rst_ni;
  logic                                       req_valid_i;
  logic                                       req_ready_o;
  vseq_pkg::op_e                              req_op_i;
  vseq_pkg::vreg_t                            req_vd_i;
  vseq_pkg::vreg_t                            req_vs1_i;
  vseq_pkg::vreg_t                            req_vs2_i;
  logic                                       req_use_vd_i;
  logic                                       req_use_vs1_i;
  logic                                       req_use_vs2_i;
  logic                                       issue_valid_o;
  logic                                       issue_ready_i;
  vseq_pkg::vid_t                             issue_id_o;
  vseq_pkg::op_e                              issue_op_o;
  vseq_pkg::unit_e                            issue_unit_o;
  vseq_pkg::vid_vec_t                         issue_hazard_o;
  vseq_pkg::vid_vec_t [vseq_pkg::NrUnits-1:0] unit_done_i;
  vseq_pkg::vid_vec_t                         running_o;
  vseq_pkg::vid_vec_t [vseq_pkg::NrVInsn-1:0] hazard_table_o;
  logic                                       idle_o;

  // Model state, registered view of the DUT
  vseq_pkg::vid_vec_t m_tbl [vseq_pkg::NrUnits];
  int                 m_cnt [vseq_pkg::NrUnits];
  vseq_pkg::vid_t     m_rd_vid [vseq_pkg::NrVRegs];
  logic               m_rd_val [vseq_pkg::NrVRegs];
  vseq_pkg::vid_t     m_wr_vid [vseq_pkg::NrVRegs];
  logic               m_wr_val [vseq_pkg::NrVRegs];
  vseq_pkg::vid_vec_t m_haz_tbl [vseq_pkg::NrVInsn];
  logic               m_iss_valid;
  vseq_pkg::vid_t     m_iss_id;
  vseq_pkg::op_e      m_iss_op;
  vseq_pkg::unit_e    m_iss_unit;
  vseq_pkg::vid_vec_t m_iss_haz;

  logic [31:0] lcg_state = 32'h1c6d;
  int          n_checks = 0;
  int          n_errors = 0;
  int          n_timeouts = 0;
  int          n_accepts = 0;
  // Last sampled DUT status, used by the wait loops
  logic        seen_ready;
  logic        seen_issue_valid;
  logic        seen_idle;

  vseq_top #(
    .QueueDepth (QueueDepth)
  ) vseq_top_i (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .req_valid_i    (req_valid_i),
    .req_ready_o    (req_ready_o),
    .req_op_i       (req_op_i),
    .req_vd_i       (req_vd_i),
    .req_vs1_i      (req_vs1_i),
    .req_vs2_i      (req_vs2_i),
    .req_use_vd_i   (req_use_vd_i),
    .req_use_vs1_i  (req_use_vs1_i),
    .req_use_vs2_i  (req_use_vs2_i),
    .issue_valid_o  (issue_valid_o),
    .issue_ready_i  (issue_ready_i),
    .issue_id_o     (issue_id_o),
    .issue_op_o     (issue_op_o),
    .issue_unit_o   (issue_unit_o),
    .issue_hazard_o (issue_hazard_o),
    .unit_done_i    (unit_done_i),
    .running_o      (running_o),
    .hazard_table_o (hazard_table_o),
    .idle_o         (idle_o)
  );

  always #5 clk_i = ~clk_i;

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  function automatic int unsigned rand_below(input int unsigned n);
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return (lcg_state >> 8) % n;
  endfunction

  // Unit that owns an operation code
  function automatic vseq_pkg::unit_e unit_of(input vseq_pkg::op_e op);
    if (op <= vseq_pkg::VOR) return vseq_pkg::UNIT_ALU;
    if (op <= vseq_pkg::VMACC) return vseq_pkg::UNIT_MUL;
    if (op == vseq_pkg::VLE) return vseq_pkg::UNIT_LOAD;
    return vseq_pkg::UNIT_STORE;
  endfunction

  function automatic vseq_pkg::vid_t lowest_free(input vseq_pkg::vid_vec_t run);
    logic found;
    lowest_free = '0;
    found = 1'b0;
    for (int i = 0; i < vseq_pkg::NrVInsn; i++) begin
      if (!found && !run[i]) begin
        lowest_free = vseq_pkg::vid_t'(i);
        found = 1'b1;
      end
    end
  endfunction

  // One-hot owner of a list entry, empty unless the owner keeps running
  function automatic vseq_pkg::vid_vec_t live_owner(input logic valid, input vseq_pkg::vid_t vid,
                                                    input vseq_pkg::vid_vec_t run);
    live_owner = '0;
    if (valid && run[vid]) live_owner[vid] = 1'b1;
  endfunction

  task automatic check_bit(input string name, input logic got, input logic exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("[ERROR] %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_vid(input string name, input vseq_pkg::vid_t got,
                           input vseq_pkg::vid_t exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("[ERROR] %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_vec(input string name, input vseq_pkg::vid_vec_t got,
                           input vseq_pkg::vid_vec_t exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("[ERROR] %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_op(input string name, input vseq_pkg::op_e got, input vseq_pkg::op_e exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("[ERROR] %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_unit(input string name, input vseq_pkg::unit_e got,
                            input vseq_pkg::unit_e exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("[ERROR] %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic reset_model();
    for (int u = 0; u < vseq_pkg::NrUnits; u++) begin
      m_tbl[u] = '0;
      m_cnt[u] = 0;
    end
    for (int r = 0; r < vseq_pkg::NrVRegs; r++) begin
      m_rd_vid[r] = '0;
      m_rd_val[r] = 1'b0;
      m_wr_vid[r] = '0;
      m_wr_val[r] = 1'b0;
    end
    for (int i = 0; i < vseq_pkg::NrVInsn; i++) m_haz_tbl[i] = '0;
    m_iss_valid = 1'b0;
  endtask

  //////////////////////////////////////////////////
  // One clock cycle: drive, check, advance model
  //////////////////////////////////////////////////

  // Entered and left 1 ns after a rising edge
  task automatic run_cycle(input int unsigned valid_pct, input int unsigned ready_pct,
                           input logic done_en);
    vseq_pkg::vid_vec_t done [vseq_pkg::NrUnits];
    vseq_pkg::vid_vec_t tbl_n [vseq_pkg::NrUnits];
    vseq_pkg::vid_vec_t run_q, run_n, war, h_vs1, h_vs2, h_vd, h_any;
    vseq_pkg::vid_t     free;
    vseq_pkg::unit_e    unit;
    logic               ready, acc, up, down;
    int unsigned        start, idx;
    // Few registers so that hazards show up often
    req_valid_i   = rand_below(100) < valid_pct;
    req_op_i      = vseq_pkg::op_e'(rand_below(8));
    req_vd_i      = vseq_pkg::vreg_t'(rand_below(8));
    req_vs1_i     = vseq_pkg::vreg_t'(rand_below(8));
    req_vs2_i     = vseq_pkg::vreg_t'(rand_below(8));
    req_use_vd_i  = rand_below(4) != 0;
    req_use_vs1_i = rand_below(4) != 0;
    req_use_vs2_i = rand_below(2) != 0;
    issue_ready_i = rand_below(100) < ready_pct;
    // At most one completion per unit, only for an id it runs
    for (int u = 0; u < vseq_pkg::NrUnits; u++) begin
      done[u] = '0;
      if (done_en && m_tbl[u] != '0 && rand_below(100) < 35) begin
        start = rand_below(vseq_pkg::NrVInsn);
        for (int k = 0; k < vseq_pkg::NrVInsn; k++) begin
          idx = (start + k) % vseq_pkg::NrVInsn;
          if (done[u] == '0 && m_tbl[u][idx]) done[u][idx] = 1'b1;
        end
      end
      unit_done_i[u] = done[u];
    end

    @(negedge clk_i);
    run_q = '0;
    for (int u = 0; u < vseq_pkg::NrUnits; u++) run_q |= m_tbl[u];
    // Registered outputs
    check_bit("issue_valid_o", issue_valid_o, m_iss_valid);
    if (m_iss_valid) begin
      check_vid("issue_id_o", issue_id_o, m_iss_id);
      check_op("issue_op_o", issue_op_o, m_iss_op);
      check_unit("issue_unit_o", issue_unit_o, m_iss_unit);
      check_vec("issue_hazard_o", issue_hazard_o, m_iss_haz);
    end
    check_vec("running_o", running_o, run_q);
    check_bit("idle_o", idle_o, run_q == '0);
    for (int i = 0; i < vseq_pkg::NrVInsn; i++) begin
      check_vec($sformatf("hazard_table_o[%0d]", i), hazard_table_o[i], m_haz_tbl[i]);
    end
    seen_ready       = req_ready_o;
    seen_issue_valid = issue_valid_o;
    seen_idle        = idle_o;

    // Accept decision of the model
    free  = lowest_free(run_q);
    unit  = unit_of(req_op_i);
    ready = !(m_iss_valid && !issue_ready_i) && (run_q != '1) && (m_cnt[unit] < QueueDepth);
    check_bit("req_ready_o", req_ready_o, ready);
    acc = req_valid_i && ready;

    run_n = '0;
    for (int u = 0; u < vseq_pkg::NrUnits; u++) begin
      tbl_n[u] = m_tbl[u] & ~done[u];
      if (acc && unit == vseq_pkg::unit_e'(u)) tbl_n[u][free] = 1'b1;
      run_n |= tbl_n[u];
    end

    // WAR reaches every field, RAW the sources, WAW the destination
    war   = req_use_vd_i ? live_owner(m_rd_val[req_vd_i], m_rd_vid[req_vd_i], run_n) : '0;
    h_vs1 = war;
    h_vs2 = war;
    h_vd  = war;
    if (req_use_vs1_i) h_vs1 |= live_owner(m_wr_val[req_vs1_i], m_wr_vid[req_vs1_i], run_n);
    if (req_use_vs2_i) h_vs2 |= live_owner(m_wr_val[req_vs2_i], m_wr_vid[req_vs2_i], run_n);
    if (req_use_vd_i) h_vd |= live_owner(m_wr_val[req_vd_i], m_wr_vid[req_vd_i], run_n);
    h_any = h_vs1 | h_vs2 | h_vd;

    // Stale list entries drop, then the accepted request claims its registers
    for (int r = 0; r < vseq_pkg::NrVRegs; r++) begin
      m_rd_val[r] = m_rd_val[r] && run_n[m_rd_vid[r]];
      m_wr_val[r] = m_wr_val[r] && run_n[m_wr_vid[r]];
    end
    if (acc) begin
      if (req_use_vd_i) begin
        m_wr_vid[req_vd_i] = free;
        m_wr_val[req_vd_i] = 1'b1;
      end
      if (req_use_vs1_i) begin
        m_rd_vid[req_vs1_i] = free;
        m_rd_val[req_vs1_i] = 1'b1;
      end
      if (req_use_vs2_i) begin
        m_rd_vid[req_vs2_i] = free;
        m_rd_val[req_vs2_i] = 1'b1;
      end
    end
    for (int i = 0; i < vseq_pkg::NrVInsn; i++) begin
      if (acc && free == vseq_pkg::vid_t'(i)) m_haz_tbl[i] = h_any;
      m_haz_tbl[i] &= run_n;
    end
    for (int u = 0; u < vseq_pkg::NrUnits; u++) begin
      up   = acc && unit == vseq_pkg::unit_e'(u);
      down = done[u] != '0;
      if (up && !down) m_cnt[u]++;
      else if (down && !up) m_cnt[u]--;
      m_tbl[u] = tbl_n[u];
    end
    // Issue slot loads on accept and empties once consumed
    if (acc) begin
      m_iss_valid = 1'b1;
      m_iss_id    = free;
      m_iss_op    = req_op_i;
      m_iss_unit  = unit;
      m_iss_haz   = h_any;
      n_accepts++;
    end else if (issue_ready_i) begin
      m_iss_valid = 1'b0;
    end
    @(posedge clk_i);
    #1;
  endtask

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial begin
    int k;
    int start_acc;
    rst_ni        = 1'b0;
    req_valid_i   = 1'b0;
    req_op_i      = vseq_pkg::VADD;
    req_vd_i      = '0;
    req_vs1_i     = '0;
    req_vs2_i     = '0;
    req_use_vd_i  = 1'b0;
    req_use_vs1_i = 1'b0;
    req_use_vs2_i = 1'b0;
    issue_ready_i = 1'b1;
    unit_done_i   = '0;
    reset_model();
    repeat (5) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;

    // State right after reset
    check_bit("issue_valid_o", issue_valid_o, 1'b0);
    check_vec("running_o", running_o, '0);
    check_bit("idle_o", idle_o, 1'b1);
    for (int i = 0; i < vseq_pkg::NrVInsn; i++) begin
      check_vec($sformatf("hazard_table_o[%0d]", i), hazard_table_o[i], '0);
    end

    // Mixed traffic with completions
    repeat (400) run_cycle(70, 85, 1'b1);

    // Hold completions back until a queue or the id pool fills
    seen_ready = 1'b1;
    k = 0;
    while (seen_ready && k < 40) begin
      run_cycle(100, 100, 1'b0);
      k++;
    end
    if (seen_ready) begin
      $display("Timeout: req_ready_o never dropped while completions were held back");
      n_timeouts++;
    end

    // Completions must let requests in again
    start_acc = n_accepts;
    k = 0;
    while (n_accepts == start_acc && k < 40) begin
      run_cycle(100, 100, 1'b1);
      k++;
    end
    if (n_accepts == start_acc) begin
      $display("Timeout: no request was accepted after completions resumed");
      n_timeouts++;
    end

    // Back-pressure on a pending issue
    seen_issue_valid = 1'b0;
    k = 0;
    while (!seen_issue_valid && k < 40) begin
      run_cycle(100, 100, 1'b1);
      k++;
    end
    if (!seen_issue_valid) begin
      $display("Timeout: issue_valid_o never rose before the stall test");
      n_timeouts++;
    end
    repeat (10) run_cycle(100, 0, 1'b1);
    repeat (300) run_cycle(60, 70, 1'b1);

    // Drain every running instruction
    seen_idle = 1'b0;
    k = 0;
    while (!seen_idle && k < 200) begin
      run_cycle(0, 100, 1'b1);
      k++;
    end
    if (!seen_idle) begin
      $display("Timeout: idle_o never rose while draining");
      n_timeouts++;
    end

    $display("Summary: %0d checks, %0d errors, %0d timeouts, %0d accepts",
             n_checks, n_errors, n_timeouts, n_accepts);
    if (n_errors == 0 && n_timeouts == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

//--- hw/vseq_top.sv
/*
  Top level of the vector instruction sequencer.
  Joins scoreboard, issue control, running tracker and one queue counter per
  unit. Requests enter on a valid/ready port and leave on the issue port.
*/
`timescale 1ns/1ps

module vseq_top #(
  parameter int unsigned QueueDepth = vseq_pkg::DefaultQueueDepth
) (
  input  logic                                       clk_i,
  input  logic                                       rst_ni,
  // Request side
  input  logic                                       req_valid_i,
  output logic                                       req_ready_o,
  input  vseq_pkg::op_e                              req_op_i,
  input  vseq_pkg::vreg_t                            req_vd_i,
  input  vseq_pkg::vreg_t                            req_vs1_i,
  input  vseq_pkg::vreg_t                            req_vs2_i,
  input  logic                                       req_use_vd_i,
  input  logic                                       req_use_vs1_i,
  input  logic                                       req_use_vs2_i,
  // Issue side
  output logic                                       issue_valid_o,
  input  logic                                       issue_ready_i,
  output vseq_pkg::vid_t                             issue_id_o,
  output vseq_pkg::op_e                              issue_op_o,
  output vseq_pkg::unit_e                            issue_unit_o,
  output vseq_pkg::vid_vec_t                         issue_hazard_o,
  // Completion and status
  input  vseq_pkg::vid_vec_t [vseq_pkg::NrUnits-1:0] unit_done_i,
  output vseq_pkg::vid_vec_t                         running_o,
  output vseq_pkg::vid_vec_t [vseq_pkg::NrVInsn-1:0] hazard_table_o,
  output logic                                       idle_o
);

  sb_if    sb ();
  track_if trk ();

  vseq_pkg::unit_vec_t unit_ready;
  vseq_pkg::unit_vec_t unit_up;

  vseq_scoreboard i_scoreboard (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .req_op_i       (req_op_i),
    .req_vd_i       (req_vd_i),
    .req_vs1_i      (req_vs1_i),
    .req_vs2_i      (req_vs2_i),
    .req_use_vd_i   (req_use_vd_i),
    .req_use_vs1_i  (req_use_vs1_i),
    .req_use_vs2_i  (req_use_vs2_i),
    .sb             (sb),
    .trk            (trk),
    .running_i      (running_o),
    .hazard_table_o (hazard_table_o)
  );

  vseq_issue_ctrl i_issue_ctrl (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .req_valid_i    (req_valid_i),
    .req_ready_o    (req_ready_o),
    .req_op_i       (req_op_i),
    .sb             (sb),
    .trk            (trk),
    .unit_ready_i   (unit_ready),
    .unit_up_o      (unit_up),
    .issue_valid_o  (issue_valid_o),
    .issue_ready_i  (issue_ready_i),
    .issue_id_o     (issue_id_o),
    .issue_op_o     (issue_op_o),
    .issue_unit_o   (issue_unit_o),
    .issue_hazard_o (issue_hazard_o)
  );

  vseq_running_tracker i_tracker (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .trk         (trk),
    .unit_done_i (unit_done_i),
    .running_o   (running_o)
  );

  // One queue counter per functional unit
  for (genvar u = 0; u < vseq_pkg::NrUnits; u++) begin : gen_cnt
    vseq_unit_counter #(
      .Depth (QueueDepth)
    ) i_cnt (
      .clk_i   (clk_i),
      .rst_ni  (rst_ni),
      .up_i    (unit_up[u]),
      .down_i  (trk.unit_done[u]),
      .ready_o (unit_ready[u])
    );
  end

  // Nothing in flight
  assign idle_o = ~|running_o;

endmodule

//--- hw/vseq_issue_ctrl.sv
/*
  Accept logic and registered issue stage of the sequencer.
  Takes a request when the issue slot drains, an id is free and the target
  unit has room, then presents it on the issue port the next cycle.
*/
`timescale 1ns/1ps

module vseq_issue_ctrl (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                req_valid_i,
  output logic                req_ready_o,
  input  vseq_pkg::op_e       req_op_i,
  sb_if.issue                 sb,
  track_if.issue              trk,
  input  vseq_pkg::unit_vec_t unit_ready_i,
  output vseq_pkg::unit_vec_t unit_up_o,
  output logic                issue_valid_o,
  input  logic                issue_ready_i,
  output vseq_pkg::vid_t      issue_id_o,
  output vseq_pkg::op_e       issue_op_o,
  output vseq_pkg::unit_e     issue_unit_o,
  output vseq_pkg::vid_vec_t  issue_hazard_o
);

  logic stall;
  logic accept;

  //////////////////////////////////////////////////
  // Accept decision
  //////////////////////////////////////////////////

  // Held issue blocks new requests, a consumed one does not
  assign stall       = issue_valid_o & ~issue_ready_i;
  assign req_ready_o = ~stall & ~sb.ids_full & unit_ready_i[sb.target_unit];
  assign accept      = req_valid_i & req_ready_o;

  assign sb.accept       = accept;
  assign trk.accept      = accept;
  assign trk.accept_id   = sb.free_id;
  assign trk.accept_unit = sb.target_unit;

  // Count up only on the unit the request goes to
  for (genvar u = 0; u < vseq_pkg::NrUnits; u++) begin : gen_up
    assign unit_up_o[u] = accept & (sb.target_unit == vseq_pkg::unit_e'(u));
  end

  //////////////////////////////////////////////////
  // Issue register
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      issue_valid_o <= 1'b0;
    end else if (accept) begin
      issue_valid_o <= 1'b1;
    end else if (issue_ready_i) begin
      issue_valid_o <= 1'b0;
    end
  end

  // Payload loads only on accept, so it holds through a stall
  always_ff @(posedge clk_i) begin
    if (accept) begin
      issue_id_o     <= sb.free_id;
      issue_op_o     <= req_op_i;
      issue_unit_o   <= sb.target_unit;
      issue_hazard_o <= sb.hazard.hazard_any;
    end
  end

  // Stalled issue keeps its valid and its fields
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    stall |=> issue_valid_o &&
              $stable({issue_id_o, issue_op_o, issue_unit_o, issue_hazard_o}));

endmodule

//--- hw/vseq_running_tracker.sv
/*
  Table of running instruction ids per functional unit.
  Accepted ids are marked on their unit and cleared on that unit's done bit.
  Exposes the next running vector and a per-unit completion pulse.
*/
`timescale 1ns/1ps

module vseq_running_tracker (
  input  logic                                       clk_i,
  input  logic                                       rst_ni,
  track_if.tracker                                   trk,
  input  vseq_pkg::vid_vec_t [vseq_pkg::NrUnits-1:0] unit_done_i,
  output vseq_pkg::vid_vec_t                         running_o
);

  vseq_pkg::vid_vec_t [vseq_pkg::NrUnits-1:0] table_d, table_q;
  vseq_pkg::vid_vec_t                         running_next;

  always_comb begin
    running_next = '0;
    for (int u = 0; u < vseq_pkg::NrUnits; u++) begin
      table_d[u] = table_q[u] & ~unit_done_i[u];
    end
    // New instruction lands on its unit
    if (trk.accept) table_d[trk.accept_unit][trk.accept_id] = 1'b1;
    for (int u = 0; u < vseq_pkg::NrUnits; u++) begin
      running_next |= table_d[u];
    end
  end

  // Any done bit frees one slot in that unit's queue
  for (genvar u = 0; u < vseq_pkg::NrUnits; u++) begin : gen_done
    assign trk.unit_done[u] = |unit_done_i[u];
  end

  assign trk.running_next = running_next;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      table_q   <= '0;
      running_o <= '0;
    end else begin
      table_q   <= table_d;
      running_o <= running_next;
    end
  end

  // Units report completion only for ids they actually run
  for (genvar u = 0; u < vseq_pkg::NrUnits; u++) begin : gen_chk
    assert property (@(posedge clk_i) disable iff (!rst_ni)
      (unit_done_i[u] & ~table_q[u]) == '0);
  end

endmodule

//--- hw/vseq_unit_counter.sv
/*
  Occupancy counter of one unit's instruction queue.
  Counts accepted instructions up and completions down, ready while not full.
*/
`timescale 1ns/1ps

module vseq_unit_counter #(
  parameter int unsigned Depth = vseq_pkg::DefaultQueueDepth
) (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic up_i,
  input  logic down_i,
  output logic ready_o
);

  localparam int unsigned CntW = $clog2(Depth + 1);

  logic [CntW-1:0] cnt_d, cnt_q;

  // Simultaneous up and down leave the count alone
  always_comb begin
    cnt_d = cnt_q;
    if (up_i && !down_i) cnt_d = cnt_q + 1'b1;
    else if (down_i && !up_i) cnt_d = cnt_q - 1'b1;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) cnt_q <= '0;
    else cnt_q <= cnt_d;
  end

  assign ready_o = cnt_q < CntW'(Depth);

  // Completions only for counted work, accepts only with room left
  assert property (@(posedge clk_i) disable iff (!rst_ni) down_i |-> cnt_q != '0);
  assert property (@(posedge clk_i) disable iff (!rst_ni) up_i |-> cnt_q != CntW'(Depth));

endmodule

//--- hw/scoreboard/vseq_scoreboard.sv
/*
  Hazard scoreboard of the sequencer.
  Tracks the last reader and writer of each vector register, derives RAW,
  WAR and WAW hazards for the incoming request and keeps the global hazard
  table. Also picks the lowest free instruction id and the target unit.
*/
`timescale 1ns/1ps

module vseq_scoreboard (
  input  logic                                          clk_i,
  input  logic                                          rst_ni,
  input  vseq_pkg::op_e                                 req_op_i,
  input  vseq_pkg::vreg_t                               req_vd_i,
  input  vseq_pkg::vreg_t                               req_vs1_i,
  input  vseq_pkg::vreg_t                               req_vs2_i,
  input  logic                                          req_use_vd_i,
  input  logic                                          req_use_vs1_i,
  input  logic                                          req_use_vs2_i,
  sb_if.scoreboard                                      sb,
  track_if.observer                                     trk,
  input  vseq_pkg::vid_vec_t                            running_i,
  output vseq_pkg::vid_vec_t [vseq_pkg::NrVInsn-1:0]    hazard_table_o
);

  vseq_pkg::vreg_access_t [vseq_pkg::NrVRegs-1:0] read_list_d, read_list_q;
  vseq_pkg::vreg_access_t [vseq_pkg::NrVRegs-1:0] write_list_d, write_list_q;
  logic [vseq_pkg::NrVRegs-1:0]                   rd_live, wr_live;
  vseq_pkg::vid_vec_t [vseq_pkg::NrVInsn-1:0]     table_d;
  vseq_pkg::hazard_t                              haz;
  vseq_pkg::vid_t                                 free_id;
  vseq_pkg::unit_e                                target_unit;

  //////////////////////////////////////////////////
  // Id allocation and unit decode
  //////////////////////////////////////////////////

  // Lowest id not yet running, scanned from the top down
  always_comb begin
    free_id = '0;
    for (int i = vseq_pkg::NrVInsn - 1; i >= 0; i--) begin
      if (!running_i[i]) free_id = vseq_pkg::vid_t'(i);
    end
  end

  always_comb begin
    unique case (req_op_i) inside
      [vseq_pkg::VADD:vseq_pkg::VOR]:   target_unit = vseq_pkg::UNIT_ALU;
      [vseq_pkg::VMUL:vseq_pkg::VMACC]: target_unit = vseq_pkg::UNIT_MUL;
      vseq_pkg::VLE:                    target_unit = vseq_pkg::UNIT_LOAD;
      default:                          target_unit = vseq_pkg::UNIT_STORE;
    endcase
  end

  assign sb.free_id     = free_id;
  assign sb.ids_full    = &running_i;
  assign sb.target_unit = target_unit;

  //////////////////////////////////////////////////
  // Hazards
  //////////////////////////////////////////////////

  // An entry only counts while its owner is still running next cycle
  always_comb begin
    for (int r = 0; r < vseq_pkg::NrVRegs; r++) begin
      rd_live[r] = read_list_q[r].valid & trk.running_next[read_list_q[r].vid];
      wr_live[r] = write_list_q[r].valid & trk.running_next[write_list_q[r].vid];
    end
  end

  always_comb begin
    haz = '0;
    // RAW on the sources
    if (req_use_vs1_i && wr_live[req_vs1_i]) haz.hazard_vs1[write_list_q[req_vs1_i].vid] = 1'b1;
    if (req_use_vs2_i && wr_live[req_vs2_i]) haz.hazard_vs2[write_list_q[req_vs2_i].vid] = 1'b1;
    if (req_use_vd_i) begin
      // WAR hits every operand field
      if (rd_live[req_vd_i]) begin
        haz.hazard_vs1[read_list_q[req_vd_i].vid] = 1'b1;
        haz.hazard_vs2[read_list_q[req_vd_i].vid] = 1'b1;
        haz.hazard_vd[read_list_q[req_vd_i].vid]  = 1'b1;
      end
      // WAW on the destination
      if (wr_live[req_vd_i]) haz.hazard_vd[write_list_q[req_vd_i].vid] = 1'b1;
    end
    haz.hazard_any = haz.hazard_vs1 | haz.hazard_vs2 | haz.hazard_vd;
  end

  assign sb.hazard = haz;

  //////////////////////////////////////////////////
  // Access lists and hazard table
  //////////////////////////////////////////////////

  always_comb begin
    for (int r = 0; r < vseq_pkg::NrVRegs; r++) begin
      read_list_d[r]  = '{vid: read_list_q[r].vid, valid: rd_live[r]};
      write_list_d[r] = '{vid: write_list_q[r].vid, valid: wr_live[r]};
    end
    table_d = hazard_table_o;
    if (sb.accept) begin
      if (req_use_vd_i) write_list_d[req_vd_i] = '{vid: free_id, valid: 1'b1};
      if (req_use_vs1_i) read_list_d[req_vs1_i] = '{vid: free_id, valid: 1'b1};
      if (req_use_vs2_i) read_list_d[req_vs2_i] = '{vid: free_id, valid: 1'b1};
      table_d[free_id] = haz.hazard_any;
    end
    // Finished ids drop out of every row
    for (int i = 0; i < vseq_pkg::NrVInsn; i++) table_d[i] &= trk.running_next;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      read_list_q    <= '0;
      write_list_q   <= '0;
      hazard_table_o <= '0;
    end else begin
      read_list_q    <= read_list_d;
      write_list_q   <= write_list_d;
      hazard_table_o <= table_d;
    end
  end

  // Issue control must not take a request with every id in flight
  assert property (@(posedge clk_i) disable iff (!rst_ni) sb.accept |-> !sb.ids_full);

endmodule

//--- common/vseq_if.sv
/*
  Internal interfaces of the sequencer.
  sb_if joins scoreboard and issue control, track_if carries accepts to the
  running tracker and its next running vector back to the scoreboard.
*/
`timescale 1ns/1ps

interface sb_if;
  vseq_pkg::vid_t    free_id;
  logic              ids_full;
  vseq_pkg::unit_e   target_unit;
  vseq_pkg::hazard_t hazard;
  logic              accept;

  modport scoreboard (output free_id, ids_full, target_unit, hazard, input accept);
  modport issue      (input free_id, ids_full, target_unit, hazard, output accept);
endinterface

interface track_if;
  logic                accept;
  vseq_pkg::vid_t      accept_id;
  vseq_pkg::unit_e     accept_unit;
  vseq_pkg::vid_vec_t  running_next;
  vseq_pkg::unit_vec_t unit_done;

  modport issue    (output accept, accept_id, accept_unit);
  modport tracker  (input accept, accept_id, accept_unit, output running_next, unit_done);
  modport observer (input accept, accept_id, accept_unit, running_next, unit_done);
endinterface

//--- common/vseq_pkg.sv
/*
  Shared sizes and types of the vector instruction sequencer.
  Operation codes are grouped so that each unit owns one contiguous range.
*/
package vseq_pkg;

  // Instructions in flight, register file size and functional units
  localparam int unsigned NrVInsn = 8;
  localparam int unsigned NrVRegs = 32;
  localparam int unsigned NrUnits = 4;

  // Default depth of the instruction queue of each unit
  localparam int unsigned DefaultQueueDepth = 3;

  typedef logic [$clog2(NrVInsn)-1:0] vid_t;
  typedef logic [$clog2(NrVRegs)-1:0] vreg_t;
  typedef logic [NrVInsn-1:0]         vid_vec_t;
  typedef logic [NrUnits-1:0]         unit_vec_t;

  // Ranges: ALU 0..3, multiplier 4..5, load 6, store 7
  typedef enum logic [3:0] {
    VADD  = 4'd0,
    VSUB  = 4'd1,
    VAND  = 4'd2,
    VOR   = 4'd3,
    VMUL  = 4'd4,
    VMACC = 4'd5,
    VLE   = 4'd6,
    VSE   = 4'd7
  } op_e;

  typedef enum logic [1:0] {
    UNIT_ALU   = 2'd0,
    UNIT_MUL   = 2'd1,
    UNIT_LOAD  = 2'd2,
    UNIT_STORE = 2'd3
  } unit_e;

  // Last instruction that reads or writes a register
  typedef struct packed {
    vid_t vid;
    logic valid;
  } vreg_access_t;

  // One bit per id this instruction must wait for, split by operand
  typedef struct packed {
    vid_vec_t hazard_vs1;
    vid_vec_t hazard_vs2;
    vid_vec_t hazard_vd;
    vid_vec_t hazard_any;
  } hazard_t;

endpackage
